// ==== verilog.f ====
+incdir+verilog
verilog/spi_cmd_pkg.sv
verilog/spi_phy_pkg.sv
verilog/cmd_queue.sv
verilog/sclk_gen.sv
verilog/spi_shifter.sv
verilog/spi_ctrl.sv
verilog/spi_master_top.sv
tests/spi_master_chk.sv
tests/spi_master_tb.sv

// ==== tests/spi_master_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module spi_master_tb;
  import spi_cmd_pkg::*;
  import spi_phy_pkg::*;

  localparam int NUM_CMDS   = 200;
  localparam int FRAME_CYC  = 105;
  localparam int MAX_DELAY  = 300;
  localparam int CMD_W      = `SPI_CMD_W;
  localparam int NUM_REGS   = 2 ** `SPI_ADDR_W;
  localparam int TIMEOUT_NS = (NUM_CMDS * (FRAME_CYC + MAX_DELAY) + 1000) * 40;

  logic      clk;
  logic      rst_n;
  logic      cmd_push;
  spi_cmd_t  cmd;
  logic      miso;
  logic      rsp_credit;
  logic      cmd_credit;
  spi_pins_t pins;
  logic      rsp_valid;
  spi_rsp_t  rsp;

  spi_cmd_t               sent_q[$];  // Commands in frame order.
  spi_rsp_t               exp_q[$];   // Expected read responses.
  int                     due_q[$];   // Cycles at which response credits go back.
  logic [`SPI_DATA_W-1:0] ref_regs [NUM_REGS] = '{default: '0};
  logic [`SPI_DATA_W-1:0] slave_regs [NUM_REGS] = '{default: '0};
  int                     cyc = 0;
  int                     pushed = 0;
  int                     frames = 0;
  int                     host_credits = `SPI_CMD_DEPTH;
  logic [CMD_W-1:0]       rx_frame;
  logic [`SPI_ADDR_W-1:0] rx_addr;
  int                     rx_bits;
  logic                   sclk_d = 1'b0;
  logic                   cs_d = 1'b1;

  spi_master_top DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_push   (cmd_push),
    .cmd        (cmd),
    .miso       (miso),
    .rsp_credit (rsp_credit),
    .cmd_credit (cmd_credit),
    .pins       (pins),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp)
  );

  bind spi_master_top spi_master_chk chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_push   (cmd_push),
    .cmd_credit (cmd_credit),
    .pins       (pins),
    .rsp_valid  (rsp_valid),
    .rsp_credit (rsp_credit)
  );

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "Run stopped at the first error.");
  endtask

  // One host cycle that pushes while credits last and returns response credits late.
  task automatic drive_host();
    spi_cmd_t c;
    int       avail;
    cyc++;
    avail = host_credits + int'(cmd_credit);
    cmd_push   <= 1'b0;
    rsp_credit <= 1'b0;
    if (avail > 0 && pushed < NUM_CMDS && $urandom_range(3, 0) != 0)
    begin
      c = spi_cmd_t'(CMD_W'($urandom));
      cmd_push <= 1'b1;
      cmd      <= c;
      sent_q.push_back(c);
      if (c.wr)
        ref_regs[c.addr] = c.data;
      else
        exp_q.push_back({c.addr, ref_regs[c.addr]});
      avail--;
      pushed++;
    end
    host_credits = avail;
    if (rsp_valid)
      due_q.push_back(cyc + $urandom_range(MAX_DELAY, 0));
    for (int i = 0; i < due_q.size(); i++)
    begin
      if (due_q[i] <= cyc)
      begin
        rsp_credit <= 1'b1;
        due_q.delete(i);
        break;
      end
    end
  endtask

  task automatic end_frame();
    spi_cmd_t want;
    spi_cmd_t got;
    got = rx_frame;
    if (sent_q.size() == 0)
      report_failure("A frame went out with no command pending.");
    else
    begin
      want = sent_q.pop_front();
      assert (got == want)
        else report_failure($sformatf("Error: mosi frame 0x%03h, expected 0x%03h", got, want));
      if (got.wr)
        slave_regs[got.addr] = got.data;
      frames++;
    end
  endtask

  task automatic check_response();
    spi_rsp_t want;
    if (exp_q.size() == 0)
      report_failure("A read response arrived with no read outstanding.");
    else
    begin
      want = exp_q.pop_front();
      assert (rsp.addr == want.addr)
        else report_failure($sformatf("Error: rsp.addr 0x%0h, expected 0x%0h",
                                      rsp.addr, want.addr));
      assert (rsp.data == want.data)
        else report_failure($sformatf("Error: rsp.data 0x%02h, expected 0x%02h",
                                      rsp.data, want.data));
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Mode 0 SPI slave with eight registers.
  always @(posedge clk)
  begin
    if (!pins.cs_n && cs_d)
      rx_bits = 0;
    if (!pins.cs_n && pins.sclk && !sclk_d)
    begin
      rx_frame = {rx_frame[CMD_W-2:0], pins.mosi};
      rx_bits++;
      if (rx_bits == 1 + `SPI_ADDR_W)
        rx_addr = rx_frame[`SPI_ADDR_W-1:0];
    end
    if (!pins.cs_n && !pins.sclk && sclk_d && rx_bits > `SPI_ADDR_W)
      miso <= slave_regs[rx_addr][CMD_W-1-rx_bits];  // Data MSB first.
    if (pins.cs_n && !cs_d)
      end_frame();
    if (rsp_valid)
      check_response();
    if (DUT.chk.fails != 0)
      report_failure("The bound protocol checker reported an assertion failure.");
    sclk_d = pins.sclk;
    cs_d   = pins.cs_n;
  end

  initial
  begin
    void'($urandom(32'h6a07));
    rst_n      = 1'b1;
    cmd_push   = 1'b0;
    cmd        = '0;
    miso       = 1'b0;
    rsp_credit = 1'b0;
    rst_n     <= 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    while (frames < NUM_CMDS || exp_q.size() != 0)
    begin
      @(posedge clk);
      drive_host();
    end
    repeat (20) @(posedge clk);
    if (DUT.chk.fails != 0)
      report_failure("The bound protocol checker reported an assertion failure.");
    else
    begin
      $display("Done: no errors");
      $finish;
    end
  end

  initial
  begin
    #TIMEOUT_NS;
    report_failure("Timeout: not all commands completed in time.");
  end

endmodule

`default_nettype wire

// ==== tests/spi_master_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module spi_master_chk (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   cmd_push,
  input logic                   cmd_credit,
  input spi_phy_pkg::spi_pins_t pins,
  input logic                   rsp_valid,
  input logic                   rsp_credit
);

  int   fails = 0;     // Failure count, watched by the testbench.
  int   rise_cnt;      // sclk rises in the current frame.
  int   queued;        // Commands pushed and not yet credited back.
  int   rsp_owed;      // Responses sent and not yet credited back.
  logic sclk_d;
  logic rst_q = 1'b1;

  always @(posedge clk)
    rst_q <= rst_n;

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rise_cnt <= 0;
      queued   <= 0;
      rsp_owed <= 0;
      sclk_d   <= 1'b0;
    end
    else
    begin
      sclk_d   <= pins.sclk;
      rise_cnt <= pins.cs_n ? 0 : rise_cnt + int'(pins.sclk && !sclk_d);
      queued   <= queued + int'(cmd_push) - int'(cmd_credit);
      rsp_owed <= rsp_owed + int'(rsp_valid) - int'(rsp_credit);
    end
  end

  // Covers the cycles in reset and the first one after it.
  a_reset_vals: assert property (@(posedge clk) (!rst_n || !rst_q) |->
      pins.cs_n && !pins.sclk && !pins.mosi && !rsp_valid && !cmd_credit)
    else
    begin
      $error("Outputs not at their reset values");
      fails++;
    end

  a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
      pins.cs_n |-> !pins.sclk)
    else
    begin
      $error("sclk high while cs_n is high");
      fails++;
    end

  a_frame_len: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(pins.cs_n) |-> rise_cnt == `SPI_CMD_W)
    else
    begin
      $error("Frame did not hold exactly 12 sclk rises");
      fails++;
    end

  a_credit_time: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_credit == $fell(pins.cs_n))
    else
    begin
      $error("cmd_credit not one cycle after the frame start");
      fails++;
    end

  a_push_credit: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_push |-> queued < `SPI_CMD_DEPTH)
    else
    begin
      $error("Command pushed without a credit");
      fails++;
    end

  a_rsp_credit: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_owed <= `SPI_RSP_CREDITS)
    else
    begin
      $error("More responses than response credits");
      fails++;
    end

endmodule

`default_nettype wire

// ==== verilog/spi_master_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module spi_master_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_push,
  input  spi_cmd_pkg::spi_cmd_t cmd,
  input  logic                  miso,
  input  logic                  rsp_credit,
  output logic                  cmd_credit,
  output spi_phy_pkg::spi_pins_t pins,
  output logic                  rsp_valid,
  output spi_cmd_pkg::spi_rsp_t rsp
);
  import spi_cmd_pkg::*;
  import spi_phy_pkg::*;

  spi_cmd_t               head;
  logic                   not_empty;
  logic                   pop;
  shift_ctl_t             shift_ctl;
  logic                   run;
  logic                   rise;
  logic                   fall;
  logic                   done;
  logic [`SPI_DATA_W-1:0] rx_data;
  logic                   sclk;
  logic                   cs_n;
  logic                   mosi;

  assign pins.sclk = sclk;
  assign pins.cs_n = cs_n;
  assign pins.mosi = mosi;

  cmd_queue u_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_push   (cmd_push),
    .cmd        (cmd),
    .pop        (pop),
    .head       (head),
    .not_empty  (not_empty),
    .cmd_credit (cmd_credit)
  );

  spi_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .head       (head),
    .not_empty  (not_empty),
    .rise       (rise),
    .fall       (fall),
    .done       (done),
    .rx_data    (rx_data),
    .rsp_credit (rsp_credit),
    .pop        (pop),
    .shift_ctl  (shift_ctl),
    .run        (run),
    .cs_n       (cs_n),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp)
  );

  sclk_gen u_sclk (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .sclk  (sclk),
    .rise  (rise),
    .fall  (fall)
  );

  spi_shifter u_shifter (
    .clk       (clk),
    .rst_n     (rst_n),
    .shift_ctl (shift_ctl),
    .rise      (rise),
    .fall      (fall),
    .miso      (miso),
    .mosi      (mosi),
    .rx_data   (rx_data),
    .done      (done)
  );

endmodule

`default_nettype wire

// ==== verilog/spi_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module spi_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  spi_cmd_pkg::spi_cmd_t   head,
  input  logic                    not_empty,
  input  logic                    rise,
  input  logic                    fall,
  input  logic                    done,
  input  logic [`SPI_DATA_W-1:0]  rx_data,
  input  logic                    rsp_credit,
  output logic                    pop,
  output spi_phy_pkg::shift_ctl_t shift_ctl,
  output logic                    run,
  output logic                    cs_n,
  output logic                    rsp_valid,
  output spi_cmd_pkg::spi_rsp_t   rsp
);
  import spi_phy_pkg::*;

  localparam int HW  = $clog2(`SPI_HALF_DIV + 1);
  localparam int CRW = $clog2(`SPI_RSP_CREDITS + 1);

  ctrl_state_t            state;
  logic [HW-1:0]          hcnt;
  logic [CRW-1:0]         credits;
  logic                   seen_done;
  logic                   is_read;
  logic [`SPI_ADDR_W-1:0] addr_q;
  logic                   start;
  logic                   rd_start;
  logic                   half_end;
  logic                   shift_end;

  // A read at the head blocks everything behind it until a credit is back.
  assign start     = (state == IDLE) && not_empty && (head.wr || (credits != '0));
  assign rd_start  = start && !head.wr;
  assign half_end  = (hcnt == HW'(`SPI_HALF_DIV - 1));
  assign shift_end = (state == SHIFT) && fall && seen_done;

  assign pop            = start;
  assign shift_ctl.load = start;
  assign shift_ctl.word = head;
  assign run            = (state == SHIFT);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= IDLE;
      hcnt      <= '0;
      cs_n      <= 1'b1;
      seen_done <= 1'b0;
      is_read   <= 1'b0;
      rsp_valid <= 1'b0;
    end
    else
    begin
      rsp_valid <= 1'b0;
      case (state)
        IDLE:
        begin
          if (start)
          begin
            state   <= SETUP;
            cs_n    <= 1'b0;  // First bit is already on mosi.
            hcnt    <= '0;
            is_read <= !head.wr;
          end
        end
        SETUP:
        begin
          if (half_end)
          begin
            state <= SHIFT;
            hcnt  <= '0;
          end
          else
            hcnt <= hcnt + 1'b1;
        end
        SHIFT:
        begin
          if (rise && done)
            seen_done <= 1'b1;
          if (shift_end)
          begin
            state     <= HOLD;
            cs_n      <= 1'b1;
            seen_done <= 1'b0;
            rsp_valid <= is_read;  // First cycle of HOLD.
          end
        end
        HOLD:
        begin
          if (half_end)
          begin
            state <= IDLE;
            hcnt  <= '0;
          end
          else
            hcnt <= hcnt + 1'b1;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      credits <= CRW'(`SPI_RSP_CREDITS);
    else
    begin
      case ({rsp_credit, rd_start})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // Response payload.
  always_ff @(posedge clk)
  begin
    if (start)
      addr_q <= head.addr;
    if (shift_end)
    begin
      rsp.addr <= addr_q;
      rsp.data <= rx_data;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/spi_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module spi_shifter (
  input  logic                    clk,
  input  logic                    rst_n,
  input  spi_phy_pkg::shift_ctl_t shift_ctl,
  input  logic                    rise,
  input  logic                    fall,
  input  logic                    miso,
  output logic                    mosi,
  output logic [`SPI_DATA_W-1:0]  rx_data,
  output logic                    done
);

  logic [`SPI_CMD_W-1:0] word;
  logic [3:0]            bit_cnt;

  // MSB first, so mosi is always the top of the word.
  assign mosi = word[`SPI_CMD_W-1];
  assign done = rise && (bit_cnt == 4'(`SPI_CMD_W - 1));  // 12th rise.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      word    <= '0;
      bit_cnt <= '0;
    end
    else if (shift_ctl.load)
    begin
      word    <= shift_ctl.word;
      bit_cnt <= '0;
    end
    else
    begin
      if (fall)
        word <= {word[`SPI_CMD_W-2:0], 1'b0};  // Next bit after the falling edge.
      if (rise)
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // Shifts in miso on each rise.
  always_ff @(posedge clk)
  begin
    if (rise)
      rx_data <= {rx_data[`SPI_DATA_W-2:0], miso};
  end

endmodule

`default_nettype wire

// ==== verilog/sclk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module sclk_gen #(
  parameter int HALF_DIV = `SPI_HALF_DIV
) (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  output logic sclk,
  output logic rise,
  output logic fall
);

  localparam int CW = (HALF_DIV > 1) ? $clog2(HALF_DIV) : 1;

  logic [CW-1:0] cnt;
  logic          toggle;

  assign toggle = run && (cnt == CW'(HALF_DIV - 1));  // Last cycle of a half period.
  assign rise   = toggle && !sclk;
  assign fall   = toggle && sclk;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt  <= '0;
      sclk <= 1'b0;
    end
    else if (!run)
    begin
      cnt  <= '0;
      sclk <= 1'b0;  // Idle low between frames.
    end
    else if (toggle)
    begin
      cnt  <= '0;
      sclk <= !sclk;
    end
    else
      cnt <= cnt + 1'b1;
  end

endmodule

`default_nettype wire

// ==== verilog/cmd_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spi_defines.svh"

module cmd_queue #(
  parameter int DEPTH = `SPI_CMD_DEPTH
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_push,
  input  spi_cmd_pkg::spi_cmd_t cmd,
  input  logic                  pop,
  output spi_cmd_pkg::spi_cmd_t head,
  output logic                  not_empty,
  output logic                  cmd_credit
);
  import spi_cmd_pkg::*;

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  spi_cmd_t        mem [DEPTH];
  logic [PW-1:0]   wr_ptr;
  logic [PW-1:0]   rd_ptr;
  logic [CW-1:0]   count;

  assign head      = mem[rd_ptr];
  assign not_empty = (count != '0);

  // Entry storage.
  always_ff @(posedge clk)
  begin
    if (cmd_push)
      mem[wr_ptr] <= cmd;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      cmd_credit <= 1'b0;
    end
    else
    begin
      cmd_credit <= pop;  // Credit goes back the cycle after the pop.
      if (cmd_push)
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({cmd_push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/spi_phy_pkg.sv ====
`default_nettype none

`include "spi_defines.svh"

package spi_phy_pkg;

  // Output pins of the master.
  typedef struct packed {
    logic sclk;
    logic cs_n;
    logic mosi;
  } spi_pins_t;

  // Controller to shifter.
  typedef struct packed {
    logic                  load;  // Pulses one cycle to copy word into the shifter.
    logic [`SPI_CMD_W-1:0] word;  // Frame to send.
  } shift_ctl_t;

  // Frame sequencing states.
  typedef enum logic [2:0] {
    IDLE,
    SETUP,
    SHIFT,
    HOLD
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== verilog/spi_cmd_pkg.sv ====
`default_nettype none

`include "spi_defines.svh"

package spi_cmd_pkg;

  // Host command word with fields in the order they leave on mosi.
  typedef struct packed {
    logic                   wr;    // Set for a write.
    logic [`SPI_ADDR_W-1:0] addr;  // Register address.
    logic [`SPI_DATA_W-1:0] data;  // Write data that a read ignores.
  } spi_cmd_t;

  // Read response returned to the host.
  typedef struct packed {
    logic [`SPI_ADDR_W-1:0] addr;  // Address of the read.
    logic [`SPI_DATA_W-1:0] data;  // Last bits sampled from miso.
  } spi_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/spi_defines.svh ====
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

// Command queue entries and the host's starting credit count.
`define SPI_CMD_DEPTH 4

// Response credits held by the master after reset.
`define SPI_RSP_CREDITS 2

// clk cycles per sclk half period.
`define SPI_HALF_DIV 4

`define SPI_ADDR_W 3
`define SPI_DATA_W 8

// One frame is the kind flag, the address and the data.
`define SPI_CMD_W (1 + `SPI_ADDR_W + `SPI_DATA_W)

`endif
